// ==== Makefile ====
# Verilator build and run for the transfer unit testbench

VERILATOR ?= verilator
TOP       ?= tb_kua
SEED      ?= 1996
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -GSEED=$(SEED) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== list.f ====
src/kua_pkg.sv
src/kua_decode.sv
src/kua_execute.sv
src/kua_result.sv
src/kua_top.sv
tests/tb_kua.sv

// ==== src/kua_decode.sv ====
`timescale 1ns/1ps
// Configuration handshake and job latch
// Read address generation for both buffer read ports
module kua_decode (
    input  logic              clk,
    input  logic              rst,
    input  kua_pkg::kua_cfg_t cfg,
    input  logic              cfg_valid,
    output logic              cfg_ready,
    output kua_pkg::addr_t    rd0_addr,
    output logic              rd0_addr_valid,
    input  logic              rd0_addr_ready,
    output kua_pkg::addr_t    rd1_addr,
    output logic              rd1_addr_valid,
    input  logic              rd1_addr_ready,
    output kua_pkg::kua_job_t job,
    output logic              job_start,
    input  logic              job_done
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT
    } dec_state_e;

    dec_state_e       state;
    kua_pkg::kua_op_e cfg_op;
    logic             cfg_ready_q;
    logic             cfg_fire;
    logic             rd0_fire;
    logic             rd1_fire;
    logic             blk_switch;
    kua_pkg::addr_t   rd0_addr_q;
    kua_pkg::addr_t   rd1_addr_q;
    kua_pkg::len_t    rd0_left;
    kua_pkg::len_t    rd1_left;
    logic             rd0_second;

    // Anything that is not SHF or ADD runs as CAT
    always_comb begin
        case (cfg.op)
            kua_pkg::OP_SHF: cfg_op = kua_pkg::OP_SHF;
            kua_pkg::OP_ADD: cfg_op = kua_pkg::OP_ADD;
            default:         cfg_op = kua_pkg::OP_CAT;
        endcase
    end

    assign cfg_ready      = cfg_ready_q;
    assign cfg_fire       = cfg_valid && cfg_ready_q;
    assign rd0_addr_valid = (state == ISSUE) && (rd0_left != '0);
    assign rd1_addr_valid = (state == ISSUE) && (rd1_left != '0);
    assign rd0_fire       = rd0_addr_valid && rd0_addr_ready;
    assign rd1_fire       = rd1_addr_valid && rd1_addr_ready;
    assign rd0_addr       = rd0_addr_q;
    assign rd1_addr       = rd1_addr_q;

    // Last word of the first CAT block moves port 0 onto src1
    assign blk_switch = rd0_second && (rd0_left == kua_pkg::len_t'(1));

    // ========================================
    // Job FSM
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            cfg_ready_q <= 1'b1;
            job_start   <= 1'b0;
        end else begin
            job_start <= cfg_fire;
            case (state)
                IDLE: begin
                    if (cfg_fire) begin
                        state       <= ISSUE;
                        cfg_ready_q <= 1'b0;
                    end
                end
                ISSUE: begin
                    if (!rd0_addr_valid && !rd1_addr_valid) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (job_done) begin
                        state       <= IDLE;
                        cfg_ready_q <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ========================================
    // Read address counters
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            rd0_left   <= '0;
            rd1_left   <= '0;
            rd0_second <= 1'b0;
        end else if (cfg_fire) begin
            rd0_left   <= cfg.len;
            rd1_left   <= (cfg_op == kua_pkg::OP_ADD) ? cfg.len : '0;
            rd0_second <= (cfg_op == kua_pkg::OP_CAT);
        end else begin
            if (rd0_fire) begin
                if (blk_switch) begin
                    rd0_left   <= job.len;
                    rd0_second <= 1'b0;
                end else begin
                    rd0_left <= rd0_left - kua_pkg::len_t'(1);
                end
            end
            if (rd1_fire) begin
                rd1_left <= rd1_left - kua_pkg::len_t'(1);
            end
        end
    end

    // For CAT the port 1 register just parks src1_addr
    always_ff @(posedge clk) begin
        if (cfg_fire) begin
            rd0_addr_q   <= cfg.src0_addr;
            rd1_addr_q   <= cfg.src1_addr;
            job.op       <= cfg_op;
            job.dst_addr <= cfg.dst_addr;
            job.len      <= cfg.len;
            job.shift    <= cfg.shift;
        end else begin
            if (rd0_fire) begin
                rd0_addr_q <= blk_switch ? rd1_addr_q : rd0_addr_q + kua_pkg::addr_t'(1);
            end
            if (rd1_fire) begin
                rd1_addr_q <= rd1_addr_q + kua_pkg::addr_t'(1);
            end
        end
    end

    // Accept only between jobs
    assert property (@(posedge clk) disable iff (rst) cfg_fire |-> (state == IDLE));

    // Final write can only land after every address has gone out
    assert property (@(posedge clk) disable iff (rst) job_done |-> (state == WAIT));

endmodule

// ==== src/kua_execute.sv ====
`timescale 1ns/1ps
// Read data pairing for both ports
// Element rotate, element add and pass-through into one word register
module kua_execute #(
    parameter int ELEM_WIDTH = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  kua_pkg::kua_job_t job,
    input  logic              job_start,
    input  kua_pkg::word_t    rd0_data,
    input  logic              rd0_data_valid,
    output logic              rd0_data_ready,
    input  kua_pkg::word_t    rd1_data,
    input  logic              rd1_data_valid,
    output logic              rd1_data_ready,
    output kua_pkg::word_t    exe_word,
    output logic              exe_valid,
    input  logic              exe_ready
);

    localparam int NUM_ELEM = kua_pkg::WORD_WIDTH / ELEM_WIDTH;

    kua_pkg::kua_op_e op_q;
    kua_pkg::shift_t  shift_q;
    logic             active;
    logic             is_add;
    logic             take;
    logic             fire;
    kua_pkg::word_t   word_d;
    kua_pkg::word_t   word_q;
    logic             valid_q;

    assign is_add = (op_q == kua_pkg::OP_ADD);

    // Register free or draining this cycle
    assign take = !valid_q || exe_ready;

    // ========================================
    // Input pairing
    // ========================================
    // ADD pulls one word from each port in the same cycle,
    // so each ready waits on the other port's valid
    assign rd0_data_ready = active && take && (!is_add || rd1_data_valid);
    assign rd1_data_ready = active && take && is_add && rd0_data_valid;
    assign fire           = rd0_data_valid && rd0_data_ready;

    // ========================================
    // Word operation
    // ========================================
    always_comb begin
        word_d = rd0_data;
        case (op_q)
            kua_pkg::OP_SHF: begin
                // Output element i takes input element (i + shift) mod N
                for (int i = 0; i < NUM_ELEM; i++) begin
                    word_d[i*ELEM_WIDTH +: ELEM_WIDTH] =
                        rd0_data[((i + int'(shift_q)) % NUM_ELEM)*ELEM_WIDTH +: ELEM_WIDTH];
                end
            end
            kua_pkg::OP_ADD: begin
                // Carries drop at each element boundary
                for (int i = 0; i < NUM_ELEM; i++) begin
                    word_d[i*ELEM_WIDTH +: ELEM_WIDTH] =
                        rd0_data[i*ELEM_WIDTH +: ELEM_WIDTH] +
                        rd1_data[i*ELEM_WIDTH +: ELEM_WIDTH];
                end
            end
            default: begin
                word_d = rd0_data;
            end
        endcase
    end

    // Data ports stay closed until the first job arrives
    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            if (job_start) begin
                active <= 1'b1;
            end
            if (take) begin
                valid_q <= fire;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (job_start) begin
            op_q    <= job.op;
            shift_q <= job.shift;
        end
        if (fire) begin
            word_q <= word_d;
        end
    end

    assign exe_word  = word_q;
    assign exe_valid = valid_q;

    // Port 1 data only moves while decode holds an ADD job
    assert property (@(posedge clk) disable iff (rst)
        (rd1_data_valid && rd1_data_ready) |-> (job.op == kua_pkg::OP_ADD));

endmodule

// ==== src/kua_pkg.sv ====
// Buffer widths and the meaningful vector types
// Opcode encoding plus configuration, job and write structs
package kua_pkg;

    // ========================================
    // Widths
    // ========================================
    localparam int ADDR_WIDTH = 16;
    localparam int WORD_WIDTH = 64;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [WORD_WIDTH-1:0] word_t;

    // Block length in words, at least one
    typedef logic [7:0] len_t;

    // Rotate amount, counted in elements
    typedef logic [3:0] shift_t;

    // ========================================
    // Opcodes and grouped signals
    // ========================================
    typedef enum logic [1:0] {
        OP_SHF = 2'd1,
        OP_ADD = 2'd2,
        OP_CAT = 2'd3
    } kua_op_e;

    typedef struct packed {
        kua_op_e op;
        addr_t   src0_addr;
        addr_t   src1_addr;
        addr_t   dst_addr;
        len_t    len;
        shift_t  shift;
    } kua_cfg_t;

    // Per-job view handed to execute and result
    typedef struct packed {
        kua_op_e op;
        addr_t   dst_addr;
        len_t    len;
        shift_t  shift;
    } kua_job_t;

    typedef struct packed {
        addr_t addr;
        word_t data;
    } kua_wr_t;

endpackage

// ==== src/kua_result.sv ====
`timescale 1ns/1ps
// Output register with write addressing
// Write counting and end-of-job pulse
module kua_result (
    input  logic              clk,
    input  logic              rst,
    input  kua_pkg::kua_job_t job,
    input  logic              job_start,
    input  kua_pkg::word_t    exe_word,
    input  logic              exe_valid,
    output logic              exe_ready,
    output kua_pkg::kua_wr_t  wr,
    output logic              wr_valid,
    input  logic              wr_ready,
    output logic              job_done
);

    // One bit wider than len, CAT writes twice the block
    typedef logic [$bits(kua_pkg::len_t):0] cnt_t;

    kua_pkg::addr_t   dst_q;
    cnt_t             total_q;
    cnt_t             in_cnt;
    cnt_t             wr_cnt;
    logic             load;
    logic             wr_fire;
    kua_pkg::kua_wr_t wr_q;
    logic             wr_valid_q;

    assign exe_ready = !wr_valid_q || wr_ready;
    assign load      = exe_valid && exe_ready;
    assign wr_fire   = wr_valid_q && wr_ready;
    assign job_done  = wr_fire && (wr_cnt == total_q - cnt_t'(1));

    assign wr       = wr_q;
    assign wr_valid = wr_valid_q;

    // ========================================
    // Control and counters
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_valid_q <= 1'b0;
            in_cnt     <= '0;
            wr_cnt     <= '0;
        end else begin
            if (exe_ready) begin
                wr_valid_q <= exe_valid;
            end
            if (job_start) begin
                in_cnt <= '0;
                wr_cnt <= '0;
            end else begin
                if (load) begin
                    in_cnt <= in_cnt + cnt_t'(1);
                end
                if (wr_fire) begin
                    wr_cnt <= wr_cnt + cnt_t'(1);
                end
            end
        end
    end

    // Address follows the number of words taken in
    always_ff @(posedge clk) begin
        if (job_start) begin
            dst_q   <= job.dst_addr;
            total_q <= (job.op == kua_pkg::OP_CAT) ? {job.len, 1'b0} : {1'b0, job.len};
        end
        if (load) begin
            wr_q.addr <= dst_q + kua_pkg::addr_t'(in_cnt);
            wr_q.data <= exe_word;
        end
    end

    // Stalled write holds its payload
    assert property (@(posedge clk) disable iff (rst)
        (wr_valid && !wr_ready) |=> (wr_valid && $stable(wr)));

endmodule

// ==== src/kua_top.sv ====
`timescale 1ns/1ps
// Transfer unit top with decode, execute and result stages
module kua_top #(
    parameter int ELEM_WIDTH = 8
) (
    input  logic              clk,
    input  logic              rst,

    // Configuration
    input  kua_pkg::kua_cfg_t cfg,
    input  logic              cfg_valid,
    output logic              cfg_ready,

    // Read port 0
    output kua_pkg::addr_t    rd0_addr,
    output logic              rd0_addr_valid,
    input  logic              rd0_addr_ready,
    input  kua_pkg::word_t    rd0_data,
    input  logic              rd0_data_valid,
    output logic              rd0_data_ready,

    // Read port 1, ADD only
    output kua_pkg::addr_t    rd1_addr,
    output logic              rd1_addr_valid,
    input  logic              rd1_addr_ready,
    input  kua_pkg::word_t    rd1_data,
    input  logic              rd1_data_valid,
    output logic              rd1_data_ready,

    // Write port
    output kua_pkg::kua_wr_t  wr,
    output logic              wr_valid,
    input  logic              wr_ready
);

    kua_pkg::kua_job_t job;
    logic              job_start;
    logic              job_done;
    kua_pkg::word_t    exe_word;
    logic              exe_valid;
    logic              exe_ready;

    // ========================================
    // Stages
    // ========================================
    kua_decode u_decode (
        .clk            (clk),
        .rst            (rst),
        .cfg            (cfg),
        .cfg_valid      (cfg_valid),
        .cfg_ready      (cfg_ready),
        .rd0_addr       (rd0_addr),
        .rd0_addr_valid (rd0_addr_valid),
        .rd0_addr_ready (rd0_addr_ready),
        .rd1_addr       (rd1_addr),
        .rd1_addr_valid (rd1_addr_valid),
        .rd1_addr_ready (rd1_addr_ready),
        .job            (job),
        .job_start      (job_start),
        .job_done       (job_done)
    );

    kua_execute #(
        .ELEM_WIDTH (ELEM_WIDTH)
    ) u_execute (
        .clk            (clk),
        .rst            (rst),
        .job            (job),
        .job_start      (job_start),
        .rd0_data       (rd0_data),
        .rd0_data_valid (rd0_data_valid),
        .rd0_data_ready (rd0_data_ready),
        .rd1_data       (rd1_data),
        .rd1_data_valid (rd1_data_valid),
        .rd1_data_ready (rd1_data_ready),
        .exe_word       (exe_word),
        .exe_valid      (exe_valid),
        .exe_ready      (exe_ready)
    );

    kua_result u_result (
        .clk       (clk),
        .rst       (rst),
        .job       (job),
        .job_start (job_start),
        .exe_word  (exe_word),
        .exe_valid (exe_valid),
        .exe_ready (exe_ready),
        .wr        (wr),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .job_done  (job_done)
    );

endmodule

// ==== tests/tb_kua.sv ====
`timescale 1ns/1ps
// Transfer unit testbench with a buffer memory model and random stalls
// Random SHF, ADD and CAT jobs, reference model, write checks and watchdog
module tb_kua #(
    parameter int SEED = 1996
);

    localparam int ELEM_WIDTH     = 8;
    localparam int NUM_ELEM       = kua_pkg::WORD_WIDTH / ELEM_WIDTH;
    localparam int CLK_PERIOD     = 4;
    localparam int NUM_JOBS       = 30;
    localparam int MAX_LEN        = 12;
    localparam int MEM_WORDS      = 1 << kua_pkg::ADDR_WIDTH;
    localparam int TIMEOUT_CYCLES = NUM_JOBS * 2 * MAX_LEN * 20;

    logic              clk            = 1'b0;
    logic              rst            = 1'b1;
    kua_pkg::kua_cfg_t cfg            = '0;
    logic              cfg_valid      = 1'b0;
    logic              cfg_ready;
    kua_pkg::addr_t    rd0_addr;
    logic              rd0_addr_valid;
    logic              rd0_addr_ready = 1'b0;
    kua_pkg::word_t    rd0_data       = '0;
    logic              rd0_data_valid = 1'b0;
    logic              rd0_data_ready;
    kua_pkg::addr_t    rd1_addr;
    logic              rd1_addr_valid;
    logic              rd1_addr_ready = 1'b0;
    kua_pkg::word_t    rd1_data       = '0;
    logic              rd1_data_valid = 1'b0;
    logic              rd1_data_ready;
    kua_pkg::kua_wr_t  wr;
    logic              wr_valid;
    logic              wr_ready       = 1'b0;

    integer            seed = SEED;
    bit                prepared = 1'b0;
    kua_pkg::word_t    mem [MEM_WORDS];
    kua_pkg::kua_cfg_t jobs [NUM_JOBS];
    int                job_words [NUM_JOBS];
    bit                job_add [NUM_JOBS];
    kua_pkg::addr_t    exp_addr [$];
    kua_pkg::word_t    exp_data [$];
    kua_pkg::addr_t    pend0 [$];
    kua_pkg::addr_t    pend1 [$];
    kua_pkg::addr_t    rd_a;
    int                errors = 0;
    int                wr_idx = 0;
    int                words_left = 0;
    int                jobs_started = 0;
    int                jobs_done = 0;
    bit                busy = 1'b0;
    bit                cur_add = 1'b0;

    kua_top #(
        .ELEM_WIDTH (ELEM_WIDTH)
    ) uut (
        .clk (clk), .rst (rst),
        .cfg (cfg), .cfg_valid (cfg_valid), .cfg_ready (cfg_ready),
        .rd0_addr (rd0_addr), .rd0_addr_valid (rd0_addr_valid),
        .rd0_addr_ready (rd0_addr_ready), .rd0_data (rd0_data),
        .rd0_data_valid (rd0_data_valid), .rd0_data_ready (rd0_data_ready),
        .rd1_addr (rd1_addr), .rd1_addr_valid (rd1_addr_valid),
        .rd1_addr_ready (rd1_addr_ready), .rd1_data (rd1_data),
        .rd1_data_valid (rd1_data_valid), .rd1_data_ready (rd1_data_ready),
        .wr (wr), .wr_valid (wr_valid), .wr_ready (wr_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================
    // Reference model
    // ========================================
    // Output element i is input element (i + s) mod N
    function automatic kua_pkg::word_t rotate_elems(kua_pkg::word_t w, kua_pkg::shift_t s);
        int k;
        k = int'(s) % NUM_ELEM;
        if (k == 0) return w;
        return (w >> (k * ELEM_WIDTH)) | (w << ((NUM_ELEM - k) * ELEM_WIDTH));
    endfunction

    // Lane add that keeps every carry inside its own element
    function automatic kua_pkg::word_t add_elems(kua_pkg::word_t a, kua_pkg::word_t b);
        kua_pkg::word_t msb_mask;
        msb_mask = '0;
        for (int i = 0; i < NUM_ELEM; i++) begin
            msb_mask[i*ELEM_WIDTH + ELEM_WIDTH - 1] = 1'b1;
        end
        return ((a & ~msb_mask) + (b & ~msb_mask)) ^ ((a ^ b) & msb_mask);
    endfunction

    task automatic fill_memory();
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = {$random(seed), $random(seed)};
        end
    endtask

    task automatic build_jobs();
        kua_pkg::kua_cfg_t c;
        logic [1:0]        op;
        int                n;
        for (int j = 0; j < NUM_JOBS; j++) begin
            // First three jobs run SHF, ADD and CAT in order
            // Opcode 0 in later jobs runs as CAT
            op = (j < 3) ? 2'(j + 1) : 2'({$random(seed)} % 4);
            c.op        = kua_pkg::kua_op_e'(op);
            c.src0_addr = kua_pkg::addr_t'($random(seed));
            c.src1_addr = kua_pkg::addr_t'($random(seed));
            c.dst_addr  = kua_pkg::addr_t'($random(seed));
            c.len       = kua_pkg::len_t'(1 + {$random(seed)} % MAX_LEN);
            c.shift     = kua_pkg::shift_t'($random(seed));
            jobs[j]     = c;
            job_add[j]  = (op == kua_pkg::OP_ADD);
            n           = int'(c.len);
            for (int k = 0; k < n; k++) begin
                exp_addr.push_back(c.dst_addr + kua_pkg::addr_t'(k));
                case (op)
                    kua_pkg::OP_SHF:
                        exp_data.push_back(rotate_elems(mem[c.src0_addr + kua_pkg::addr_t'(k)],
                                                        c.shift));
                    kua_pkg::OP_ADD:
                        exp_data.push_back(add_elems(mem[c.src0_addr + kua_pkg::addr_t'(k)],
                                                     mem[c.src1_addr + kua_pkg::addr_t'(k)]));
                    default:
                        exp_data.push_back(mem[c.src0_addr + kua_pkg::addr_t'(k)]);
                endcase
            end
            job_words[j] = n;
            // Second CAT block lands right behind the first
            if (op != kua_pkg::OP_SHF && op != kua_pkg::OP_ADD) begin
                for (int k = 0; k < n; k++) begin
                    exp_addr.push_back(c.dst_addr + kua_pkg::addr_t'(n + k));
                    exp_data.push_back(mem[c.src1_addr + kua_pkg::addr_t'(k)]);
                end
                job_words[j] = 2 * n;
            end
        end
    endtask

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // ========================================
    // Buffer memory model
    // ========================================
    always @(posedge clk) begin
        if (rst) begin
            if (!prepared) begin
                fill_memory();
                build_jobs();
                prepared = 1'b1;
            end
            rd0_addr_ready <= 1'b0;
            rd1_addr_ready <= 1'b0;
            rd0_data_valid <= 1'b0;
            rd1_data_valid <= 1'b0;
            wr_ready       <= 1'b0;
        end else begin
            if (rd0_addr_valid && rd0_addr_ready) pend0.push_back(rd0_addr);
            if (rd1_addr_valid && rd1_addr_ready) pend1.push_back(rd1_addr);
            // Each word holds until taken and the next follows after a random gap
            if (!rd0_data_valid || rd0_data_ready) begin
                if (pend0.size() != 0 && ({$random(seed)} % 4) != 0) begin
                    rd_a = pend0.pop_front();
                    rd0_data       <= mem[rd_a];
                    rd0_data_valid <= 1'b1;
                end else begin
                    rd0_data_valid <= 1'b0;
                end
            end
            if (!rd1_data_valid || rd1_data_ready) begin
                if (pend1.size() != 0 && ({$random(seed)} % 4) != 0) begin
                    rd_a = pend1.pop_front();
                    rd1_data       <= mem[rd_a];
                    rd1_data_valid <= 1'b1;
                end else begin
                    rd1_data_valid <= 1'b0;
                end
            end
            rd0_addr_ready <= ({$random(seed)} % 4) != 0;
            rd1_addr_ready <= ({$random(seed)} % 4) != 0;
            wr_ready       <= ({$random(seed)} % 3) != 0;
        end
    end

    // ========================================
    // Monitor
    // ========================================
    always @(posedge clk) begin
        if (!rst) begin
            if (busy) begin
                if (cfg_ready) begin
                    $display("ERROR at %0t: cfg_ready is high before the job finished", $time);
                    errors++;
                end
                if (rd1_addr_valid && !cur_add) begin
                    $display("ERROR at %0t: port 1 read address issued outside ADD", $time);
                    errors++;
                end
            end else begin
                // Idle between jobs and right after reset
                check_equal("cfg_ready", 64'(cfg_ready), 64'(1));
                check_equal("wr_valid", 64'(wr_valid), 64'(0));
                check_equal("rd0_addr_valid", 64'(rd0_addr_valid), 64'(0));
                check_equal("rd1_addr_valid", 64'(rd1_addr_valid), 64'(0));
                // Data ports stay closed until the first job
                if (jobs_started == 0) begin
                    check_equal("rd0_data_ready", 64'(rd0_data_ready), 64'(0));
                    check_equal("rd1_data_ready", 64'(rd1_data_ready), 64'(0));
                end
            end
            if (wr_valid && wr_ready) begin
                if (!busy || wr_idx >= exp_addr.size()) begin
                    $display("ERROR at %0t: write to %h while no job is running",
                             $time, wr.addr);
                    errors++;
                end else begin
                    check_equal("wr.addr", 64'(wr.addr), 64'(exp_addr[wr_idx]));
                    check_equal("wr.data", wr.data, exp_data[wr_idx]);
                    wr_idx++;
                    words_left--;
                    if (words_left == 0) begin
                        busy = 1'b0;
                        jobs_done++;
                    end
                end
            end
            if (cfg_valid && cfg_ready && jobs_started < NUM_JOBS) begin
                busy       = 1'b1;
                words_left = job_words[jobs_started];
                cur_add    = job_add[jobs_started];
                jobs_started++;
            end
        end
    end

    // ========================================
    // Stimulus and end of run
    // ========================================
    initial begin
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        // Next configuration waits on cfg_ready with valid held high
        for (int j = 0; j < NUM_JOBS; j++) begin
            cfg       <= jobs[j];
            cfg_valid <= 1'b1;
            do @(posedge clk); while (!cfg_ready);
        end
        cfg_valid <= 1'b0;
        wait (jobs_done == NUM_JOBS);
        repeat (4) @(posedge clk);
        $display("Errors: %0d, jobs finished: %0d of %0d", errors, jobs_done, NUM_JOBS);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #((TIMEOUT_CYCLES + 16) * CLK_PERIOD);
        $display("ERROR: run did not finish within %0d cycles, %0d of %0d jobs done",
                 TIMEOUT_CYCLES, jobs_done, NUM_JOBS);
        $display("Errors: %0d, jobs finished: %0d of %0d", errors, jobs_done, NUM_JOBS);
        $display("TB FAILED");
        $finish;
    end

endmodule
